/* hw/tlb_addr_pkg.sv */
// 4 KiB pages only, no superpages or guest stage; 4-bit ASID and 32-bit stored pte
package tlb_addr_pkg;

  // ----------------------------------------
  // virtual address split
  // ----------------------------------------

  // full virtual address as issued by the walker
  localparam int unsigned VADDR_W = 39;
  // only base pages are held
  localparam int unsigned PAGE_OFFSET_W = 12;
  // page number above the offset
  localparam int unsigned VPN_W = VADDR_W - PAGE_OFFSET_W;
  // set index, taken from the low end of the vpn
  localparam int unsigned IDX_W = 2;
  // stored tag, the vpn bits above the index
  localparam int unsigned TAG_W = VPN_W - IDX_W;

  // ----------------------------------------
  // identifier and entry
  // ----------------------------------------

  localparam int unsigned ASID_W = 4;
  localparam int unsigned PTE_W = 32;
  // global mapping, ASID is a don't care for such entries
  localparam int unsigned PTE_G_BIT = 5;

endpackage

/* hw/tlb_ctrl_pkg.sv */
// geometry is fixed at 4 sets by 4 ways; the tree layout assumes exactly 4 ways
package tlb_ctrl_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------

  localparam int unsigned NUM_SETS = 4;
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned WAY_IDX_W = 2;
  // root, node for ways 0/1, node for ways 2/3
  localparam int unsigned PLRU_W = 3;

  // control FSM, reset value is FLUSH so the arrays are cleared first
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    UPDATE
  } tlb_state_e;

endpackage

/* hw/tlb_fsm.sv */
// strobes are only taken in IDLE; callers must space them two cycles apart
`timescale 1ns/1ns

module tlb_fsm (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                upd_valid_i,
  input  logic                                req_valid_i,
  input  logic [tlb_addr_pkg::VPN_W-1:0]      upd_vpn_i,
  input  logic [tlb_addr_pkg::VADDR_W-1:0]    req_vaddr_i,
  input  logic [tlb_addr_pkg::IDX_W-1:0]      flush_idx_i,
  input  logic                                flush_last_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]   victim_i,
  output logic                                flush_en_o,
  output logic                                wr_en_o,
  output logic                                rd_en_o,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0]   way_req_o,
  output logic [tlb_addr_pkg::IDX_W-1:0]      set_addr_o,
  output tlb_ctrl_pkg::tlb_state_e            state_o,
  output logic                                flushing_o
);

  tlb_ctrl_pkg::tlb_state_e state_q, state_d;

  always_comb begin
    state_d    = state_q;
    flush_en_o = 1'b0;
    wr_en_o    = 1'b0;
    rd_en_o    = 1'b0;
    unique case (state_q)
      tlb_ctrl_pkg::FLUSH: begin
        // one set cleared per cycle
        flush_en_o = 1'b1;
        if (flush_last_i) begin
          state_d = tlb_ctrl_pkg::IDLE;
        end
      end
      tlb_ctrl_pkg::IDLE: begin
        // flush beats update beats request
        if (flush_i) begin
          state_d = tlb_ctrl_pkg::FLUSH;
        end else if (upd_valid_i) begin
          wr_en_o = 1'b1;
          state_d = tlb_ctrl_pkg::UPDATE;
        end else if (req_valid_i) begin
          rd_en_o = 1'b1;
          state_d = tlb_ctrl_pkg::READ;
        end
      end
      // single cycle states, a flush here still wins
      tlb_ctrl_pkg::READ, tlb_ctrl_pkg::UPDATE: begin
        state_d = flush_i ? tlb_ctrl_pkg::FLUSH : tlb_ctrl_pkg::IDLE;
      end
      default: begin
        state_d = tlb_ctrl_pkg::FLUSH;
      end
    endcase
  end

  // set address: flush counter, then update index, else request index
  assign set_addr_o = flush_en_o ? flush_idx_i :
                      wr_en_o    ? upd_vpn_i[tlb_addr_pkg::IDX_W-1:0] :
                      req_vaddr_i[tlb_addr_pkg::PAGE_OFFSET_W +: tlb_addr_pkg::IDX_W];

  // reads and flushes touch all ways, writes only the victim
  assign way_req_o = (rd_en_o || flush_en_o) ? '1 : (wr_en_o ? victim_i : '0);

  // raised in the strobe cycle already, before the state changes
  assign flushing_o = flush_en_o | flush_i;
  assign state_o    = state_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tlb_ctrl_pkg::FLUSH;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hw/tlb_flush_counter.sv */
// counts only while flushing and wraps after the last set, so each flush starts at set 0
`timescale 1ns/1ns

module tlb_flush_counter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_en_i,
  output logic [tlb_addr_pkg::IDX_W-1:0]  flush_idx_o,
  output logic                            flush_last_o
);

  logic [tlb_addr_pkg::IDX_W-1:0] idx_q;

  // last set reached, FSM leaves FLUSH on this cycle
  assign flush_last_o = (idx_q == tlb_addr_pkg::IDX_W'(tlb_ctrl_pkg::NUM_SETS - 1));
  assign flush_idx_o  = idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (flush_en_i) begin
      if (flush_last_o) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

/* hw/tlb_tag_array.sv */
// read data is registered and holds until the next read; tag and ASID words have no reset
`timescale 1ns/1ns

module tlb_tag_array (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                     way_req_i,
  input  logic                                                  wr_en_i,
  input  logic                                                  rd_en_i,
  input  logic                                                  flush_en_i,
  input  logic [tlb_addr_pkg::IDX_W-1:0]                        set_addr_i,
  input  logic [tlb_addr_pkg::VPN_W-1:0]                        upd_vpn_i,
  input  logic [tlb_addr_pkg::ASID_W-1:0]                       upd_asid_i,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::TAG_W-1:0]  tag_o,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::ASID_W-1:0] asid_o,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                     valid_o
);

  for (genvar w = 0; w < tlb_ctrl_pkg::NUM_WAYS; w++) begin : gen_way
    logic [tlb_addr_pkg::TAG_W-1:0]  tag_mem  [tlb_ctrl_pkg::NUM_SETS];
    logic [tlb_addr_pkg::ASID_W-1:0] asid_mem [tlb_ctrl_pkg::NUM_SETS];
    logic [tlb_ctrl_pkg::NUM_SETS-1:0] valid_q;
    logic [tlb_addr_pkg::TAG_W-1:0]  tag_rd_q;
    logic [tlb_addr_pkg::ASID_W-1:0] asid_rd_q;
    logic                            valid_rd_q;

    // tag and ASID words, tag is the vpn above the index
    always_ff @(posedge clk_i) begin
      if (way_req_i[w] && wr_en_i) begin
        tag_mem[set_addr_i]  <= upd_vpn_i[tlb_addr_pkg::VPN_W-1:tlb_addr_pkg::IDX_W];
        asid_mem[set_addr_i] <= upd_asid_i;
      end else if (way_req_i[w] && rd_en_i) begin
        tag_rd_q  <= tag_mem[set_addr_i];
        asid_rd_q <= asid_mem[set_addr_i];
      end
    end

    // valid bits, flush clears and write sets
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q    <= '0;
        valid_rd_q <= 1'b0;
      end else if (way_req_i[w]) begin
        if (flush_en_i) begin
          valid_q[set_addr_i] <= 1'b0;
        end else if (wr_en_i) begin
          valid_q[set_addr_i] <= 1'b1;
        end else if (rd_en_i) begin
          valid_rd_q <= valid_q[set_addr_i];
        end
      end
    end

    assign tag_o[w]   = tag_rd_q;
    assign asid_o[w]  = asid_rd_q;
    assign valid_o[w] = valid_rd_q;
  end

endmodule

/* hw/tlb_content_array.sv */
// no reset and no flush, entries are only meaningful behind a valid tag
`timescale 1ns/1ns

module tlb_content_array (
  input  logic                                                  clk_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                     way_req_i,
  input  logic                                                  wr_en_i,
  input  logic                                                  rd_en_i,
  input  logic [tlb_addr_pkg::IDX_W-1:0]                        set_addr_i,
  input  logic [tlb_addr_pkg::PTE_W-1:0]                        upd_pte_i,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::PTE_W-1:0]  pte_o
);

  for (genvar w = 0; w < tlb_ctrl_pkg::NUM_WAYS; w++) begin : gen_way
    logic [tlb_addr_pkg::PTE_W-1:0] pte_mem [tlb_ctrl_pkg::NUM_SETS];
    logic [tlb_addr_pkg::PTE_W-1:0] pte_rd_q;

    // write wins, read word held until the next read
    always_ff @(posedge clk_i) begin
      if (way_req_i[w] && wr_en_i) begin
        pte_mem[set_addr_i] <= upd_pte_i;
      end else if (way_req_i[w] && rd_en_i) begin
        pte_rd_q <= pte_mem[set_addr_i];
      end
    end

    assign pte_o[w] = pte_rd_q;
  end

endmodule

/* hw/tlb_lookup.sv */
// response is combinational in READ only; a flush in that cycle drops it
`timescale 1ns/1ns

module tlb_lookup (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  flush_i,
  input  tlb_ctrl_pkg::tlb_state_e                              state_i,
  input  logic [tlb_addr_pkg::VADDR_W-1:0]                      req_vaddr_i,
  input  logic [tlb_addr_pkg::ASID_W-1:0]                       req_asid_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::TAG_W-1:0]  tag_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::ASID_W-1:0] asid_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                     valid_i,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::PTE_W-1:0]  pte_i,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                     hit_ways_o,
  output logic [tlb_addr_pkg::IDX_W-1:0]                        req_idx_o,
  output logic                                                  resp_valid_o,
  output logic [tlb_addr_pkg::VPN_W-1:0]                        resp_vpn_o,
  output logic [tlb_addr_pkg::ASID_W-1:0]                       resp_asid_o,
  output logic [tlb_addr_pkg::PTE_W-1:0]                        resp_pte_o
);

  logic [tlb_addr_pkg::VADDR_W-1:0]   vaddr_q;
  logic [tlb_addr_pkg::ASID_W-1:0]    asid_q;
  logic [tlb_addr_pkg::TAG_W-1:0]     req_tag;
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]  hit;
  logic [tlb_ctrl_pkg::WAY_IDX_W-1:0] hit_idx;

  // ----------------------------------------
  // request register, sampled every cycle
  // ----------------------------------------
  // holds the accepted request during READ
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vaddr_q <= '0;
      asid_q  <= '0;
    end else begin
      vaddr_q <= req_vaddr_i;
      asid_q  <= req_asid_i;
    end
  end

  assign req_idx_o = vaddr_q[tlb_addr_pkg::PAGE_OFFSET_W +: tlb_addr_pkg::IDX_W];
  assign req_tag   = vaddr_q[tlb_addr_pkg::VADDR_W-1 -: tlb_addr_pkg::TAG_W];

  // ----------------------------------------
  // match and lowest-way priority
  // ----------------------------------------
  always_comb begin
    hit        = '0;
    hit_idx    = '0;
    hit_ways_o = '0;
    for (int w = 0; w < tlb_ctrl_pkg::NUM_WAYS; w++) begin
      // global entries skip the ASID compare
      hit[w] = (state_i == tlb_ctrl_pkg::READ) && !flush_i && valid_i[w] &&
               (tag_i[w] == req_tag) &&
               ((asid_i[w] == asid_q) || pte_i[w][tlb_addr_pkg::PTE_G_BIT]);
    end
    // walk downwards so the lowest hitting way is the one kept
    for (int w = tlb_ctrl_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit[w]) begin
        hit_idx = tlb_ctrl_pkg::WAY_IDX_W'(w);
      end
    end
    if (|hit) begin
      hit_ways_o[hit_idx] = 1'b1;
    end
  end

  // vpn rebuilt from stored tag and request index
  assign resp_valid_o = |hit;
  assign resp_vpn_o   = {tag_i[hit_idx], req_idx_o};
  assign resp_asid_o  = asid_i[hit_idx];
  assign resp_pte_o   = pte_i[hit_idx];

endmodule

/* hw/tlb_plru.sv */
// tree-based pseudo-LRU for exactly 4 ways; updates on accessed hits only, never on fills
`timescale 1ns/1ns

module tlb_plru (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]   hit_ways_i,
  input  logic                                lu_access_i,
  input  logic [tlb_addr_pkg::IDX_W-1:0]      req_idx_i,
  input  logic [tlb_addr_pkg::VPN_W-1:0]      upd_vpn_i,
  output logic [tlb_ctrl_pkg::NUM_WAYS-1:0]   victim_o
);

  // node 0 is the root, node 1 covers ways 0/1, node 2 covers ways 2/3
  // a node value of 0 points left (lower ways), 1 points right
  logic [tlb_ctrl_pkg::PLRU_W-1:0]    tree_q [tlb_ctrl_pkg::NUM_SETS];
  logic [tlb_ctrl_pkg::WAY_IDX_W-1:0] hit_way;
  logic [tlb_ctrl_pkg::PLRU_W-1:0]    upd_tree;
  logic [tlb_ctrl_pkg::WAY_IDX_W-1:0] victim_way;

  // one-hot hit to way number
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < tlb_ctrl_pkg::NUM_WAYS; w++) begin
      if (hit_ways_i[w]) begin
        hit_way = tlb_ctrl_pkg::WAY_IDX_W'(w);
      end
    end
  end

  // ----------------------------------------
  // tree update on accessed hit
  // ----------------------------------------
  // nodes on the hit path turn away from the hit way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < tlb_ctrl_pkg::NUM_SETS; s++) begin
        tree_q[s] <= '0;
      end
    end else if (lu_access_i && |hit_ways_i) begin
      tree_q[req_idx_i][0]              <= ~hit_way[1];
      tree_q[req_idx_i][1 + hit_way[1]] <= ~hit_way[0];
    end
  end

  // ----------------------------------------
  // victim decode for the update's set
  // ----------------------------------------
  assign upd_tree = tree_q[upd_vpn_i[tlb_addr_pkg::IDX_W-1:0]];

  always_comb begin
    // root picks the half, the lower node picks the way inside it
    victim_way    = {upd_tree[0], upd_tree[0] ? upd_tree[2] : upd_tree[1]};
    victim_o      = '0;
    victim_o[victim_way] = 1'b1;
  end

endmodule

/* hw/set_tlb.sv */
// one request in flight, no back-pressure; wait for flushing_o low before issuing strobes
`timescale 1ns/1ns

module set_tlb (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              upd_valid_i,
  input  logic [tlb_addr_pkg::VPN_W-1:0]    upd_vpn_i,
  input  logic [tlb_addr_pkg::ASID_W-1:0]   upd_asid_i,
  input  logic [tlb_addr_pkg::PTE_W-1:0]    upd_pte_i,
  input  logic                              req_valid_i,
  input  logic [tlb_addr_pkg::VADDR_W-1:0]  req_vaddr_i,
  input  logic [tlb_addr_pkg::ASID_W-1:0]   req_asid_i,
  input  logic                              lu_access_i,
  output logic                              resp_valid_o,
  output logic [tlb_addr_pkg::VPN_W-1:0]    resp_vpn_o,
  output logic [tlb_addr_pkg::ASID_W-1:0]   resp_asid_o,
  output logic [tlb_addr_pkg::PTE_W-1:0]    resp_pte_o,
  output logic                              flushing_o
);

  // array control from the FSM
  logic                                   flush_en, wr_en, rd_en;
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]      way_req;
  logic [tlb_addr_pkg::IDX_W-1:0]         set_addr;
  tlb_ctrl_pkg::tlb_state_e               state;
  // flush walk
  logic [tlb_addr_pkg::IDX_W-1:0]         flush_idx;
  logic                                   flush_last;
  // per-way read data
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::TAG_W-1:0]  tag_rd;
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::ASID_W-1:0] asid_rd;
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]                           valid_rd;
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0][tlb_addr_pkg::PTE_W-1:0]  pte_rd;
  // replacement
  logic [tlb_ctrl_pkg::NUM_WAYS-1:0]      hit_ways, victim;
  logic [tlb_addr_pkg::IDX_W-1:0]         req_idx;

  tlb_fsm u_fsm (
    .clk_i, .rst_ni, .flush_i, .upd_valid_i, .req_valid_i, .upd_vpn_i, .req_vaddr_i,
    .flush_idx_i (flush_idx), .flush_last_i (flush_last), .victim_i (victim),
    .flush_en_o  (flush_en),  .wr_en_o      (wr_en),      .rd_en_o  (rd_en),
    .way_req_o   (way_req),   .set_addr_o   (set_addr),   .state_o  (state),
    .flushing_o
  );

  tlb_flush_counter u_flush_counter (
    .clk_i, .rst_ni, .flush_en_i (flush_en),
    .flush_idx_o (flush_idx), .flush_last_o (flush_last)
  );

  tlb_tag_array u_tag_array (
    .clk_i, .rst_ni, .way_req_i (way_req), .wr_en_i (wr_en), .rd_en_i (rd_en),
    .flush_en_i (flush_en), .set_addr_i (set_addr), .upd_vpn_i, .upd_asid_i,
    .tag_o (tag_rd), .asid_o (asid_rd), .valid_o (valid_rd)
  );

  tlb_content_array u_content_array (
    .clk_i, .way_req_i (way_req), .wr_en_i (wr_en), .rd_en_i (rd_en),
    .set_addr_i (set_addr), .upd_pte_i, .pte_o (pte_rd)
  );

  tlb_lookup u_lookup (
    .clk_i, .rst_ni, .flush_i, .state_i (state), .req_vaddr_i, .req_asid_i,
    .tag_i (tag_rd), .asid_i (asid_rd), .valid_i (valid_rd), .pte_i (pte_rd),
    .hit_ways_o (hit_ways), .req_idx_o (req_idx),
    .resp_valid_o, .resp_vpn_o, .resp_asid_o, .resp_pte_o
  );

  tlb_plru u_plru (
    .clk_i, .rst_ni, .hit_ways_i (hit_ways), .lu_access_i, .req_idx_i (req_idx),
    .upd_vpn_i, .victim_o (victim)
  );

endmodule

/* verification/tlb_tb.sv */
// strobes spaced two cycles apart and never sent while flushing; needs concurrent assertion support
`timescale 1ns/1ns

module tlb_tb;

  // six tests, none of them longer than TEST_CYCLES clocks
  localparam int unsigned TEST_CYCLES = 40;
  localparam int unsigned RUN_CYCLES  = 16 + 6 * TEST_CYCLES + 50;

  logic                             clk_i, rst_ni, flush_i, upd_valid_i, req_valid_i, lu_access_i;
  logic [tlb_addr_pkg::VPN_W-1:0]   upd_vpn_i, resp_vpn_o;
  logic [tlb_addr_pkg::ASID_W-1:0]  upd_asid_i, req_asid_i, resp_asid_o;
  logic [tlb_addr_pkg::PTE_W-1:0]   upd_pte_i, resp_pte_o;
  logic [tlb_addr_pkg::VADDR_W-1:0] req_vaddr_i;
  logic                             resp_valid_o, flushing_o;

  // reference model, full vpn kept per way
  logic                            m_valid [tlb_ctrl_pkg::NUM_SETS][tlb_ctrl_pkg::NUM_WAYS];
  logic [tlb_addr_pkg::VPN_W-1:0]  m_vpn   [tlb_ctrl_pkg::NUM_SETS][tlb_ctrl_pkg::NUM_WAYS];
  logic [tlb_addr_pkg::ASID_W-1:0] m_asid  [tlb_ctrl_pkg::NUM_SETS][tlb_ctrl_pkg::NUM_WAYS];
  logic [tlb_addr_pkg::PTE_W-1:0]  m_pte   [tlb_ctrl_pkg::NUM_SETS][tlb_ctrl_pkg::NUM_WAYS];
  logic [tlb_ctrl_pkg::PLRU_W-1:0] m_tree  [tlb_ctrl_pkg::NUM_SETS];
  int                              m_flush_left;
  logic                            m_busy, m_rd_pending;
  logic [tlb_addr_pkg::VPN_W-1:0]  m_rd_vpn;
  logic [tlb_addr_pkg::ASID_W-1:0] m_rd_asid;
  // expected outputs of the current cycle
  logic                            exp_valid, exp_flushing;
  logic [tlb_addr_pkg::VPN_W-1:0]  exp_vpn;
  logic [tlb_addr_pkg::ASID_W-1:0] exp_asid;
  logic [tlb_addr_pkg::PTE_W-1:0]  exp_pte;
  int                              exp_way;
  integer                          seed = 48481;
  string                           test_name;
  int                              errors, test_errors, tests_run, tests_failed;
  logic [tlb_addr_pkg::VPN_W-1:0]  vpn_a, vpn_g, vpn_b, vpn_c, vpn_d, vpn_e, vpn_f, vpn_h;

  set_tlb UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // checks against the reference model
  // ----------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) flushing_o == exp_flushing)
    else report_mismatch("flushing_o", exp_flushing, $sampled(flushing_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) resp_valid_o == exp_valid)
    else report_mismatch("resp_valid_o", exp_valid, $sampled(resp_valid_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) exp_valid |-> (resp_vpn_o == exp_vpn))
    else report_mismatch("resp_vpn_o", exp_vpn, $sampled(resp_vpn_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) exp_valid |-> (resp_asid_o == exp_asid))
    else report_mismatch("resp_asid_o", exp_asid, $sampled(resp_asid_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) exp_valid |-> (resp_pte_o == exp_pte))
    else report_mismatch("resp_pte_o", exp_pte, $sampled(resp_pte_o));

  task automatic report_mismatch(input string what, input logic [63:0] exp_v, act_v);
    $display("mismatch in %s: %s expected %0h, actual %0h", test_name, what, exp_v, act_v);
    errors++;
    test_errors++;
  endtask

  task automatic clear_model_valid();
    m_flush_left = tlb_ctrl_pkg::NUM_SETS;
    foreach (m_valid[s, w]) begin
      m_valid[s][w] = 1'b0;
    end
  endtask

  // lowest matching way wins, global entries ignore the ASID
  task automatic predict_outputs();
    logic [tlb_addr_pkg::IDX_W-1:0] s;
    s            = m_rd_vpn[tlb_addr_pkg::IDX_W-1:0];
    exp_flushing = (m_flush_left > 0) || flush_i;
    exp_valid    = 1'b0;
    for (int w = 0; w < tlb_ctrl_pkg::NUM_WAYS; w++) begin
      if (m_rd_pending && !flush_i && !exp_valid && m_valid[s][w] && m_vpn[s][w] == m_rd_vpn &&
          (m_asid[s][w] == m_rd_asid || m_pte[s][w][tlb_addr_pkg::PTE_G_BIT])) begin
        exp_valid = 1'b1;
        exp_way   = w;
        exp_vpn   = m_vpn[s][w];
        exp_asid  = m_asid[s][w];
        exp_pte   = m_pte[s][w];
      end
    end
  endtask

  // model step on the rising edge, strobes only taken when idle
  task automatic advance_model();
    logic [tlb_addr_pkg::IDX_W-1:0] s;
    int w;
    if (m_rd_pending && lu_access_i && exp_valid) begin
      s = m_rd_vpn[tlb_addr_pkg::IDX_W-1:0];
      // nodes on the hit path point to the other child
      m_tree[s][0] = (exp_way < 2);
      if (exp_way < 2) begin
        m_tree[s][1] = (exp_way == 0);
      end else begin
        m_tree[s][2] = (exp_way == 2);
      end
    end
    m_rd_pending = 1'b0;
    if (m_flush_left > 0) begin
      m_flush_left--;
    end else if (flush_i) begin
      clear_model_valid();
      m_busy = 1'b0;
    end else if (m_busy) begin
      m_busy = 1'b0;
    end else if (upd_valid_i) begin
      s = upd_vpn_i[tlb_addr_pkg::IDX_W-1:0];
      w = m_tree[s][0] ? 2 + int'(m_tree[s][2]) : int'(m_tree[s][1]);
      m_valid[s][w] = 1'b1;
      m_vpn[s][w]   = upd_vpn_i;
      m_asid[s][w]  = upd_asid_i;
      m_pte[s][w]   = upd_pte_i;
      m_busy        = 1'b1;
    end else if (req_valid_i) begin
      m_rd_pending = 1'b1;
      m_rd_vpn     = req_vaddr_i[tlb_addr_pkg::VADDR_W-1:tlb_addr_pkg::PAGE_OFFSET_W];
      m_rd_asid    = req_asid_i;
      m_busy       = 1'b1;
    end
  endtask

  // one clock, from falling edge to falling edge; strobes last one cycle
  task automatic run_cycle();
    predict_outputs();
    @(posedge clk_i);
    advance_model();
    @(negedge clk_i);
    flush_i     = 1'b0;
    upd_valid_i = 1'b0;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_flush_done();
    int n;
    n = 0;
    while (flushing_o && n < 2 * tlb_ctrl_pkg::NUM_SETS) begin
      run_cycle();
      n++;
    end
    if (flushing_o) begin
      $display("error in %s: flushing_o still high after %0d cycles", test_name, n);
      errors++;
      test_errors++;
    end
  endtask

  task automatic write_entry(input logic [tlb_addr_pkg::VPN_W-1:0] vpn,
                             input logic [tlb_addr_pkg::ASID_W-1:0] asid,
                             input logic [tlb_addr_pkg::PTE_W-1:0] pte);
    upd_valid_i = 1'b1;
    upd_vpn_i   = vpn;
    upd_asid_i  = asid;
    upd_pte_i   = pte;
    run_cycle();
    run_cycle();
  endtask

  // access qualifier held through the READ cycle
  task automatic request_page(input logic [tlb_addr_pkg::VPN_W-1:0] vpn,
                              input logic [tlb_addr_pkg::ASID_W-1:0] asid, input logic access);
    req_valid_i = 1'b1;
    req_vaddr_i = {vpn, tlb_addr_pkg::PAGE_OFFSET_W'($random(seed))};
    req_asid_i  = asid;
    lu_access_i = access;
    run_cycle();
    run_cycle();
    lu_access_i = 1'b0;
  endtask

  task automatic flush_tlb();
    flush_i = 1'b1;
    run_cycle();
    wait_flush_done();
  endtask

  function automatic logic [tlb_addr_pkg::VPN_W-1:0] random_vpn(
      input logic [tlb_addr_pkg::IDX_W-1:0] set);
    logic [tlb_addr_pkg::VPN_W-1:0] vpn;
    vpn = tlb_addr_pkg::VPN_W'($random(seed));
    vpn[tlb_addr_pkg::IDX_W-1:0] = set;
    return vpn;
  endfunction

  function automatic logic [tlb_addr_pkg::PTE_W-1:0] random_pte(input logic global);
    logic [tlb_addr_pkg::PTE_W-1:0] pte;
    pte = $random(seed);
    pte[tlb_addr_pkg::PTE_G_BIT] = global;
    return pte;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", test_name, test_errors);
    end
  endtask

  // watchdog sized from the test lengths
  initial begin
    repeat (RUN_CYCLES) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    upd_valid_i  = 1'b0;
    req_valid_i  = 1'b0;
    lu_access_i  = 1'b0;
    upd_vpn_i    = '0;
    upd_asid_i   = '0;
    upd_pte_i    = '0;
    req_vaddr_i  = '0;
    req_asid_i   = '0;
    exp_valid    = 1'b0;
    exp_flushing = 1'b1;
    exp_way      = 0;
    m_busy       = 1'b0;
    m_rd_pending = 1'b0;
    foreach (m_tree[s]) begin
      m_tree[s] = '0;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    clear_model_valid();

    start_test("reset_flush");
    wait_flush_done();
    request_page(random_vpn(2'd0), 4'h1, 1'b0);
    finish_test();

    start_test("update_hit");
    vpn_a = random_vpn(2'd1);
    write_entry(vpn_a, 4'h3, random_pte(1'b0));
    request_page(vpn_a, 4'h3, 1'b0);
    finish_test();

    start_test("asid_global");
    request_page(vpn_a, 4'h5, 1'b0);
    vpn_g = random_vpn(2'd2);
    write_entry(vpn_g, 4'h7, random_pte(1'b1));
    request_page(vpn_g, 4'h9, 1'b0);
    finish_test();

    start_test("flush");
    flush_tlb();
    request_page(vpn_a, 4'h3, 1'b0);
    request_page(vpn_g, 4'h7, 1'b0);
    finish_test();

    // tree of set 3 untouched, both fills go to way 0
    start_test("replace_no_access");
    vpn_b = random_vpn(2'd3);
    vpn_c = random_vpn(2'd3);
    write_entry(vpn_b, 4'h4, random_pte(1'b0));
    write_entry(vpn_c, 4'h4, random_pte(1'b0));
    request_page(vpn_b, 4'h4, 1'b0);
    request_page(vpn_c, 4'h4, 1'b0);
    finish_test();

    // way 0 hit steers the fill to way 2, a way 2 hit then to way 1
    // the last fill lands on way 1 again, so only the page placed there misses
    start_test("replace_after_access");
    vpn_d = random_vpn(2'd1);
    vpn_e = random_vpn(2'd1);
    vpn_f = random_vpn(2'd1);
    vpn_h = random_vpn(2'd1);
    write_entry(vpn_d, 4'h2, random_pte(1'b0));
    request_page(vpn_d, 4'h2, 1'b1);
    write_entry(vpn_e, 4'h2, random_pte(1'b0));
    request_page(vpn_d, 4'h2, 1'b0);
    request_page(vpn_e, 4'h2, 1'b1);
    write_entry(vpn_f, 4'h2, random_pte(1'b0));
    request_page(vpn_d, 4'h2, 1'b0);
    request_page(vpn_e, 4'h2, 1'b0);
    request_page(vpn_f, 4'h2, 1'b0);
    write_entry(vpn_h, 4'h2, random_pte(1'b0));
    request_page(vpn_d, 4'h2, 1'b0);
    request_page(vpn_e, 4'h2, 1'b0);
    request_page(vpn_f, 4'h2, 1'b0);
    request_page(vpn_h, 4'h2, 1'b0);
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/tlb_addr_pkg.sv
hw/tlb_ctrl_pkg.sv
hw/tlb_fsm.sv
hw/tlb_flush_counter.sv
hw/tlb_tag_array.sv
hw/tlb_content_array.sv
hw/tlb_lookup.sv
hw/tlb_plru.sv
hw/set_tlb.sv
verification/tlb_tb.sv

/* Bender.yml */
package:
  name: set_tlb

sources:
  # packages first, then leaf modules, then the top level
  - hw/tlb_addr_pkg.sv
  - hw/tlb_ctrl_pkg.sv
  - hw/tlb_fsm.sv
  - hw/tlb_flush_counter.sv
  - hw/tlb_tag_array.sv
  - hw/tlb_content_array.sv
  - hw/tlb_lookup.sv
  - hw/tlb_plru.sv
  - hw/set_tlb.sv
  - target: test
    files:
      - verification/tlb_tb.sv
